// File: logic/guard_bus_pkg.sv
// AXI4-Lite bus definitions for the subordinate guard
// Bus widths, response codes and the request and response channel structs

package guard_bus_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Everything a manager drives
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] aw_addr;
    logic                  aw_valid;
    logic [DATA_WIDTH-1:0] w_data;
    logic [STRB_WIDTH-1:0] w_strb;
    logic                  w_valid;
    logic                  b_ready;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic                  ar_valid;
    logic                  r_ready;
  } axil_req_t;

  // Everything a subordinate drives
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    resp_e                 b_resp;
    logic                  b_valid;
    logic                  ar_ready;
    logic [DATA_WIDTH-1:0] r_data;
    resp_e                 r_resp;
    logic                  r_valid;
  } axil_rsp_t;

endpackage

// File: logic/guard_reg_pkg.sv
// Configuration register definitions for the subordinate guard
// Register offsets, budget and prescaler constants, monitor states and the
// structs between the register file and the monitors

package guard_reg_pkg;

  localparam int unsigned CNT_WIDTH     = 16;
  localparam int unsigned PRESCALER_DIV = 4;
  localparam logic [CNT_WIDTH-1:0] BUDGET_RESET = 16'd64;

  // Byte offsets on the configuration port
  typedef enum logic [7:0] {
    REG_BUDGET_WR = 8'h00,
    REG_BUDGET_RD = 8'h04,
    REG_STATUS    = 8'h08,
    REG_IRQ_ADDR  = 8'h0C,
    REG_RESET     = 8'h10
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    TIMED_OUT
  } guard_state_e;

  // Register file to monitors
  typedef struct packed {
    logic [CNT_WIDTH-1:0] budget_wr;
    logic [CNT_WIDTH-1:0] budget_rd;
    logic                 irq_clr_wr;
    logic                 irq_clr_rd;
  } reg2hw_t;

  // Monitors to register file
  typedef struct packed {
    logic                                irq_wr;
    logic                                irq_rd;
    logic [guard_bus_pkg::ADDR_WIDTH-1:0] irq_addr;
    logic                                irq_addr_valid;
    logic                                rst_req;
  } hw2reg_t;

endpackage

// File: logic/guard_cfg_regs.sv
// Configuration register file on an AXI4-Lite port
// Holds the write and read budgets, turns write-1-to-clear accesses to the
// status register into clear pulses and returns monitor state on reads

`timescale 1ns/100ps

module guard_cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  guard_bus_pkg::axil_req_t cfg_req_i,
  output guard_bus_pkg::axil_rsp_t cfg_rsp_o,
  output guard_reg_pkg::reg2hw_t   reg2hw_o,
  input  guard_reg_pkg::hw2reg_t   hw2reg_i
);

  logic wr_accept;
  logic rd_accept;
  logic b_valid_q;
  logic r_valid_q;
  logic irq_clr_wr_q;
  logic irq_clr_rd_q;
  logic [guard_reg_pkg::CNT_WIDTH-1:0] budget_wr_q;
  logic [guard_reg_pkg::CNT_WIDTH-1:0] budget_rd_q;
  logic [guard_bus_pkg::DATA_WIDTH-1:0] rd_data;
  logic [guard_bus_pkg::DATA_WIDTH-1:0] r_data_q;
  guard_bus_pkg::resp_e wr_resp;
  guard_bus_pkg::resp_e rd_resp;
  guard_bus_pkg::resp_e b_resp_q;
  guard_bus_pkg::resp_e r_resp_q;
  guard_reg_pkg::reg_addr_e wr_addr;
  guard_reg_pkg::reg_addr_e rd_addr;

  // Byte-wise update of a budget register
  function automatic logic [guard_reg_pkg::CNT_WIDTH-1:0] apply_strb(
    input logic [guard_reg_pkg::CNT_WIDTH-1:0]  old_val,
    input logic [guard_bus_pkg::DATA_WIDTH-1:0] data,
    input logic [guard_bus_pkg::STRB_WIDTH-1:0] strb
  );
    logic [guard_reg_pkg::CNT_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < guard_reg_pkg::CNT_WIDTH / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Accept only once the previous response has gone out
  assign wr_accept = cfg_req_i.aw_valid && cfg_req_i.w_valid && !b_valid_q;
  assign rd_accept = cfg_req_i.ar_valid && !r_valid_q;
  assign wr_addr   = guard_reg_pkg::reg_addr_e'(cfg_req_i.aw_addr[7:0]);
  assign rd_addr   = guard_reg_pkg::reg_addr_e'(cfg_req_i.ar_addr[7:0]);

  always_comb begin : proc_wr_decode
    wr_resp = guard_bus_pkg::SLVERR;
    case (wr_addr)
      guard_reg_pkg::REG_BUDGET_WR, guard_reg_pkg::REG_BUDGET_RD,
      guard_reg_pkg::REG_STATUS, guard_reg_pkg::REG_IRQ_ADDR,
      guard_reg_pkg::REG_RESET: wr_resp = guard_bus_pkg::OKAY;
      default: wr_resp = guard_bus_pkg::SLVERR;
    endcase
  end

  always_comb begin : proc_rd_decode
    rd_data = '0;
    rd_resp = guard_bus_pkg::OKAY;
    case (rd_addr)
      guard_reg_pkg::REG_BUDGET_WR: rd_data[guard_reg_pkg::CNT_WIDTH-1:0] = budget_wr_q;
      guard_reg_pkg::REG_BUDGET_RD: rd_data[guard_reg_pkg::CNT_WIDTH-1:0] = budget_rd_q;
      guard_reg_pkg::REG_STATUS:    rd_data[1:0] = {hw2reg_i.irq_rd, hw2reg_i.irq_wr};
      guard_reg_pkg::REG_IRQ_ADDR: begin
        if (hw2reg_i.irq_addr_valid) begin
          rd_data = hw2reg_i.irq_addr;
        end
      end
      guard_reg_pkg::REG_RESET:     rd_data[0] = hw2reg_i.rst_req;
      default:                      rd_resp = guard_bus_pkg::SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q    <= 1'b0;
      r_valid_q    <= 1'b0;
      irq_clr_wr_q <= 1'b0;
      irq_clr_rd_q <= 1'b0;
      budget_wr_q  <= guard_reg_pkg::BUDGET_RESET;
      budget_rd_q  <= guard_reg_pkg::BUDGET_RESET;
    end else begin
      if (wr_accept) begin
        b_valid_q <= 1'b1;
      end else if (cfg_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_accept) begin
        r_valid_q <= 1'b1;
      end else if (cfg_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_accept && wr_addr == guard_reg_pkg::REG_BUDGET_WR) begin
        budget_wr_q <= apply_strb(budget_wr_q, cfg_req_i.w_data, cfg_req_i.w_strb);
      end
      if (wr_accept && wr_addr == guard_reg_pkg::REG_BUDGET_RD) begin
        budget_rd_q <= apply_strb(budget_rd_q, cfg_req_i.w_data, cfg_req_i.w_strb);
      end
      // Write 1 to clear gives one pulse per status bit
      irq_clr_wr_q <= wr_accept && wr_addr == guard_reg_pkg::REG_STATUS &&
                      cfg_req_i.w_strb[0] && cfg_req_i.w_data[0];
      irq_clr_rd_q <= wr_accept && wr_addr == guard_reg_pkg::REG_STATUS &&
                      cfg_req_i.w_strb[0] && cfg_req_i.w_data[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      b_resp_q <= wr_resp;
    end
    if (rd_accept) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin : proc_rsp
    cfg_rsp_o.aw_ready = wr_accept;
    cfg_rsp_o.w_ready  = wr_accept;
    cfg_rsp_o.b_resp   = b_resp_q;
    cfg_rsp_o.b_valid  = b_valid_q;
    cfg_rsp_o.ar_ready = rd_accept;
    cfg_rsp_o.r_data   = r_data_q;
    cfg_rsp_o.r_resp   = r_resp_q;
    cfg_rsp_o.r_valid  = r_valid_q;
  end

  assign reg2hw_o.budget_wr  = budget_wr_q;
  assign reg2hw_o.budget_rd  = budget_rd_q;
  assign reg2hw_o.irq_clr_wr = irq_clr_wr_q;
  assign reg2hw_o.irq_clr_rd = irq_clr_rd_q;

endmodule

// File: logic/write_guard.sv
// Write budget monitor
// Times each write from the AW handshake to the B handshake in prescaled
// ticks and flags an overrun with an interrupt, a reset request and the
// captured AW address

`timescale 1ns/100ps

module write_guard (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 wr_en_i,
  input  guard_bus_pkg::axil_req_t             mst_req_i,
  input  guard_bus_pkg::axil_rsp_t             slv_rsp_i,
  input  logic [guard_reg_pkg::CNT_WIDTH-1:0]  budget_i,
  input  logic                                 irq_clr_i,
  input  logic                                 reset_clear_i,
  output logic                                 busy_o,
  output logic                                 irq_o,
  output logic                                 reset_req_o,
  output logic [guard_bus_pkg::ADDR_WIDTH-1:0] irq_addr_o,
  output logic                                 irq_addr_valid_o
);

  guard_reg_pkg::guard_state_e state_q;
  logic [$clog2(guard_reg_pkg::PRESCALER_DIV)-1:0] presc_q;
  logic [guard_reg_pkg::CNT_WIDTH-1:0] cnt_q;
  logic [guard_bus_pkg::ADDR_WIDTH-1:0] addr_q;
  logic irq_q;
  logic rst_req_q;
  logic tick;
  logic enq_hs;
  logic rsp_hs;

  // wr_en_i already carries aw_valid and the enable
  assign enq_hs = wr_en_i && slv_rsp_i.aw_ready && state_q == guard_reg_pkg::IDLE;
  assign rsp_hs = mst_req_i.b_ready && slv_rsp_i.b_valid;
  assign tick   = presc_q == $bits(presc_q)'(guard_reg_pkg::PRESCALER_DIV - 1);

  // Free-running tick prescaler
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      presc_q <= '0;
    end else if (tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq_hs) begin
      addr_q <= mst_req_i.aw_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= guard_reg_pkg::IDLE;
      cnt_q     <= '0;
      irq_q     <= 1'b0;
      rst_req_q <= 1'b0;
    end else begin
      case (state_q)
        guard_reg_pkg::IDLE: begin
          if (enq_hs) begin
            state_q <= guard_reg_pkg::BUSY;
            cnt_q   <= '0;
          end
        end
        guard_reg_pkg::BUSY: begin
          // A response in the same cycle still counts as in time
          if (rsp_hs) begin
            state_q <= guard_reg_pkg::IDLE;
          end else if (cnt_q > budget_i) begin
            state_q   <= guard_reg_pkg::TIMED_OUT;
            irq_q     <= 1'b1;
            rst_req_q <= 1'b1;
          end else if (tick) begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        guard_reg_pkg::TIMED_OUT: begin
          if (irq_clr_i) begin
            irq_q <= 1'b0;
          end
          if (reset_clear_i) begin
            rst_req_q <= 1'b0;
          end
          if (!irq_q && !rst_req_q) begin
            state_q <= guard_reg_pkg::IDLE;
          end
        end
        default: state_q <= guard_reg_pkg::IDLE;
      endcase
    end
  end

  assign busy_o           = state_q == guard_reg_pkg::BUSY;
  assign irq_o            = irq_q;
  assign reset_req_o      = rst_req_q;
  assign irq_addr_o       = addr_q;
  assign irq_addr_valid_o = state_q == guard_reg_pkg::TIMED_OUT;

endmodule

// File: logic/read_guard.sv
// Read budget monitor
// Times each read from the AR handshake to the R handshake and reports an
// overrun with the captured AR address

`timescale 1ns/100ps

module read_guard (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 rd_en_i,
  input  guard_bus_pkg::axil_req_t             mst_req_i,
  input  guard_bus_pkg::axil_rsp_t             slv_rsp_i,
  input  logic [guard_reg_pkg::CNT_WIDTH-1:0]  budget_i,
  input  logic                                 irq_clr_i,
  input  logic                                 reset_clear_i,
  output logic                                 busy_o,
  output logic                                 irq_o,
  output logic                                 reset_req_o,
  output logic [guard_bus_pkg::ADDR_WIDTH-1:0] irq_addr_o,
  output logic                                 irq_addr_valid_o
);

  guard_reg_pkg::guard_state_e state_q;
  logic [$clog2(guard_reg_pkg::PRESCALER_DIV)-1:0] presc_q;
  logic [guard_reg_pkg::CNT_WIDTH-1:0] cnt_q;
  logic [guard_bus_pkg::ADDR_WIDTH-1:0] addr_q;
  logic irq_q;
  logic rst_req_q;
  logic tick;
  logic enq_hs;
  logic rsp_hs;

  assign enq_hs = rd_en_i && slv_rsp_i.ar_ready && state_q == guard_reg_pkg::IDLE;
  assign rsp_hs = mst_req_i.r_ready && slv_rsp_i.r_valid;
  assign tick   = presc_q == $bits(presc_q)'(guard_reg_pkg::PRESCALER_DIV - 1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      presc_q <= '0;
    end else if (tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq_hs) begin
      addr_q <= mst_req_i.ar_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= guard_reg_pkg::IDLE;
      cnt_q     <= '0;
      irq_q     <= 1'b0;
      rst_req_q <= 1'b0;
    end else begin
      case (state_q)
        guard_reg_pkg::IDLE: begin
          if (enq_hs) begin
            state_q <= guard_reg_pkg::BUSY;
            cnt_q   <= '0;
          end
        end
        guard_reg_pkg::BUSY: begin
          if (rsp_hs) begin
            state_q <= guard_reg_pkg::IDLE;
          end else if (cnt_q > budget_i) begin
            state_q   <= guard_reg_pkg::TIMED_OUT;
            irq_q     <= 1'b1;
            rst_req_q <= 1'b1;
          end else if (tick) begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        guard_reg_pkg::TIMED_OUT: begin
          if (irq_clr_i) begin
            irq_q <= 1'b0;
          end
          if (reset_clear_i) begin
            rst_req_q <= 1'b0;
          end
          // Leave only once both software and reset controller are done
          if (!irq_q && !rst_req_q) begin
            state_q <= guard_reg_pkg::IDLE;
          end
        end
        default: state_q <= guard_reg_pkg::IDLE;
      endcase
    end
  end

  assign busy_o           = state_q == guard_reg_pkg::BUSY;
  assign irq_o            = irq_q;
  assign reset_req_o      = rst_req_q;
  assign irq_addr_o       = addr_q;
  assign irq_addr_valid_o = state_q == guard_reg_pkg::TIMED_OUT;

endmodule

// File: logic/slv_guard_top.sv
// Subordinate guard top level
// Passes AXI4-Lite traffic through, times it with the write and read
// monitors, isolates the subordinate after an overrun and merges the
// monitor outputs for the configuration registers

`timescale 1ns/100ps

module slv_guard_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     guard_ena_i,
  input  guard_bus_pkg::axil_req_t mgr_req_i,
  output guard_bus_pkg::axil_rsp_t mgr_rsp_o,
  output guard_bus_pkg::axil_req_t sub_req_o,
  input  guard_bus_pkg::axil_rsp_t sub_rsp_i,
  input  guard_bus_pkg::axil_req_t cfg_req_i,
  output guard_bus_pkg::axil_rsp_t cfg_rsp_o,
  output logic                     irq_o,
  output logic                     rst_req_o,
  input  logic                     rst_stat_i
);

  guard_reg_pkg::reg2hw_t reg2hw;
  guard_reg_pkg::hw2reg_t hw2reg;
  guard_bus_pkg::axil_req_t req_wr;
  guard_bus_pkg::axil_req_t req_rd;
  guard_bus_pkg::axil_rsp_t rsp_wr;
  guard_bus_pkg::axil_rsp_t rsp_rd;
  logic [guard_bus_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [guard_bus_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic wr_addr_valid;
  logic rd_addr_valid;
  logic wr_busy;
  logic rd_busy;
  logic wr_irq;
  logic rd_irq;
  logic wr_rst_req;
  logic rd_rst_req;
  logic wr_enqueue;
  logic rd_enqueue;
  logic isolate;

  guard_cfg_regs i_regs (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .reg2hw_o  ( reg2hw    ),
    .hw2reg_i  ( hw2reg    )
  );

  assign isolate    = guard_ena_i && (irq_o || rst_req_o);
  assign wr_enqueue = mgr_req_i.aw_valid && guard_ena_i && !isolate;
  assign rd_enqueue = mgr_req_i.ar_valid && guard_ena_i && !isolate;

  always_comb begin : proc_gate
    sub_req_o = mgr_req_i;
    mgr_rsp_o = sub_rsp_i;
    // One outstanding transaction per direction
    if (wr_busy) begin
      sub_req_o.aw_valid = 1'b0;
      mgr_rsp_o.aw_ready = 1'b0;
    end
    if (rd_busy) begin
      sub_req_o.ar_valid = 1'b0;
      mgr_rsp_o.ar_ready = 1'b0;
    end
    if (isolate) begin
      sub_req_o.aw_valid = 1'b0;
      sub_req_o.w_valid  = 1'b0;
      sub_req_o.b_ready  = 1'b0;
      sub_req_o.ar_valid = 1'b0;
      sub_req_o.r_ready  = 1'b0;
      mgr_rsp_o.aw_ready = 1'b0;
      mgr_rsp_o.w_ready  = 1'b0;
      mgr_rsp_o.b_valid  = 1'b0;
      mgr_rsp_o.ar_ready = 1'b0;
      mgr_rsp_o.r_valid  = 1'b0;
    end
  end

  // Monitors see the manager-side handshakes
  always_comb begin : proc_split
    req_wr          = mgr_req_i;
    req_wr.ar_addr  = '0;
    req_wr.ar_valid = 1'b0;
    req_wr.r_ready  = 1'b0;
    rsp_wr          = mgr_rsp_o;
    rsp_wr.ar_ready = 1'b0;
    rsp_wr.r_data   = '0;
    rsp_wr.r_resp   = guard_bus_pkg::OKAY;
    rsp_wr.r_valid  = 1'b0;
    req_rd          = mgr_req_i;
    req_rd.aw_addr  = '0;
    req_rd.aw_valid = 1'b0;
    req_rd.w_data   = '0;
    req_rd.w_strb   = '0;
    req_rd.w_valid  = 1'b0;
    req_rd.b_ready  = 1'b0;
    rsp_rd          = mgr_rsp_o;
    rsp_rd.aw_ready = 1'b0;
    rsp_rd.w_ready  = 1'b0;
    rsp_rd.b_resp   = guard_bus_pkg::OKAY;
    rsp_rd.b_valid  = 1'b0;
  end

  write_guard i_write_guard (
    .clk_i            ( clk_i             ),
    .rst_n_i          ( rst_n_i           ),
    .wr_en_i          ( wr_enqueue        ),
    .mst_req_i        ( req_wr            ),
    .slv_rsp_i        ( rsp_wr            ),
    .budget_i         ( reg2hw.budget_wr  ),
    .irq_clr_i        ( reg2hw.irq_clr_wr ),
    .reset_clear_i    ( rst_stat_i        ),
    .busy_o           ( wr_busy           ),
    .irq_o            ( wr_irq            ),
    .reset_req_o      ( wr_rst_req        ),
    .irq_addr_o       ( wr_addr           ),
    .irq_addr_valid_o ( wr_addr_valid     )
  );

  read_guard i_read_guard (
    .clk_i            ( clk_i             ),
    .rst_n_i          ( rst_n_i           ),
    .rd_en_i          ( rd_enqueue        ),
    .mst_req_i        ( req_rd            ),
    .slv_rsp_i        ( rsp_rd            ),
    .budget_i         ( reg2hw.budget_rd  ),
    .irq_clr_i        ( reg2hw.irq_clr_rd ),
    .reset_clear_i    ( rst_stat_i        ),
    .busy_o           ( rd_busy           ),
    .irq_o            ( rd_irq            ),
    .reset_req_o      ( rd_rst_req        ),
    .irq_addr_o       ( rd_addr           ),
    .irq_addr_valid_o ( rd_addr_valid     )
  );

  assign irq_o     = wr_irq | rd_irq;
  assign rst_req_o = wr_rst_req | rd_rst_req;

  always_comb begin : proc_merge
    hw2reg.irq_wr         = wr_irq;
    hw2reg.irq_rd         = rd_irq;
    hw2reg.rst_req        = rst_req_o;
    hw2reg.irq_addr_valid = wr_addr_valid | rd_addr_valid;
    // Write side wins when both captured an address
    if (wr_addr_valid) begin
      hw2reg.irq_addr = wr_addr;
    end else if (rd_addr_valid) begin
      hw2reg.irq_addr = rd_addr;
    end else begin
      hw2reg.irq_addr = '0;
    end
  end

endmodule

// File: sim/axil_sub_model.sv
// AXI4-Lite subordinate model for the guard testbench
// Answers OKAY after a programmable latency, returns address-derived read
// data and acknowledges reset requests after a fixed delay

`timescale 1ns/100ps

module axil_sub_model #(
  parameter int unsigned RST_DELAY = 6
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [15:0]              latency_i,
  input  guard_bus_pkg::axil_req_t req_i,
  output guard_bus_pkg::axil_rsp_t rsp_o,
  input  logic                     rst_req_i,
  output logic                     rst_stat_o
);

  logic wr_busy_q;
  logic rd_busy_q;
  logic b_valid_q;
  logic r_valid_q;
  logic rst_req_q;
  logic wr_accept;
  logic rd_accept;
  logic [15:0] wr_cnt_q;
  logic [15:0] rd_cnt_q;
  logic [7:0] rst_cnt_q;
  logic [31:0] r_data_q;

  assign wr_accept = req_i.aw_valid && req_i.w_valid && !wr_busy_q && !b_valid_q;
  assign rd_accept = req_i.ar_valid && !rd_busy_q && !r_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_busy_q  <= 1'b0;
      rd_busy_q  <= 1'b0;
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
      rst_req_q  <= 1'b0;
      rst_stat_o <= 1'b0;
      wr_cnt_q   <= '0;
      rd_cnt_q   <= '0;
      rst_cnt_q  <= '0;
      r_data_q   <= '0;
    end else begin
      rst_req_q  <= rst_req_i;
      rst_stat_o <= 1'b0;
      if (rst_req_i && !rst_req_q) begin
        rst_cnt_q <= 8'(RST_DELAY);
      end else if (rst_cnt_q != 0) begin
        rst_cnt_q <= rst_cnt_q - 1'b1;
      end
      // Reset done drops any pending transaction
      if (rst_cnt_q == 1) begin
        rst_stat_o <= 1'b1;
        wr_busy_q  <= 1'b0;
        rd_busy_q  <= 1'b0;
        b_valid_q  <= 1'b0;
        r_valid_q  <= 1'b0;
      end else begin
        if (wr_accept) begin
          wr_busy_q <= 1'b1;
          wr_cnt_q  <= latency_i;
        end else if (wr_busy_q) begin
          if (wr_cnt_q <= 1) begin
            wr_busy_q <= 1'b0;
            b_valid_q <= 1'b1;
          end else begin
            wr_cnt_q <= wr_cnt_q - 1'b1;
          end
        end
        if (b_valid_q && req_i.b_ready) begin
          b_valid_q <= 1'b0;
        end
        if (rd_accept) begin
          rd_busy_q <= 1'b1;
          rd_cnt_q  <= latency_i;
          r_data_q  <= req_i.ar_addr ^ 32'h5a5a0000;
        end else if (rd_busy_q) begin
          if (rd_cnt_q <= 1) begin
            rd_busy_q <= 1'b0;
            r_valid_q <= 1'b1;
          end else begin
            rd_cnt_q <= rd_cnt_q - 1'b1;
          end
        end
        if (r_valid_q && req_i.r_ready) begin
          r_valid_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_accept;
    rsp_o.w_ready  = wr_accept;
    rsp_o.b_resp   = guard_bus_pkg::OKAY;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.ar_ready = rd_accept;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = guard_bus_pkg::OKAY;
    rsp_o.r_valid  = r_valid_q;
  end

endmodule

// File: sim/tb_slv_guard.sv
// Testbench for the subordinate guard
// Reads operations from the stimulus file, drives the manager and
// configuration ports and checks responses, interrupts and isolation

`timescale 1ns/100ps

module tb_slv_guard;

  localparam int CLK_PERIOD   = 8;
  localparam int PROBE_CYCLES = 20;
  localparam int CFG_WAIT     = 50;

  logic clk_i;
  logic rst_n_i;
  logic guard_ena_i;
  logic irq_o;
  logic rst_req_o;
  logic rst_stat_i;
  logic [15:0] sub_latency;
  guard_bus_pkg::axil_req_t mgr_req;
  guard_bus_pkg::axil_req_t sub_req;
  guard_bus_pkg::axil_req_t cfg_req;
  guard_bus_pkg::axil_rsp_t mgr_rsp;
  guard_bus_pkg::axil_rsp_t sub_rsp;
  guard_bus_pkg::axil_rsp_t cfg_rsp;

  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  int          lat_q[$];
  string       exp_q[$];
  int          errors;
  int          max_lat;
  bit          stim_loaded;

  slv_guard_top uut (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .guard_ena_i ( guard_ena_i ),
    .mgr_req_i   ( mgr_req     ),
    .mgr_rsp_o   ( mgr_rsp     ),
    .sub_req_o   ( sub_req     ),
    .sub_rsp_i   ( sub_rsp     ),
    .cfg_req_i   ( cfg_req     ),
    .cfg_rsp_o   ( cfg_rsp     ),
    .irq_o       ( irq_o       ),
    .rst_req_o   ( rst_req_o   ),
    .rst_stat_i  ( rst_stat_i  )
  );

  axil_sub_model i_sub (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .latency_i  ( sub_latency ),
    .req_i      ( sub_req     ),
    .rsp_o      ( sub_rsp     ),
    .rst_req_i  ( rst_req_o   ),
    .rst_stat_o ( rst_stat_i  )
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    errors++;
    $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic load_stimulus();
    int fd;
    int n;
    int l;
    string line;
    string op;
    string ex;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("sim/guard_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %d %s", op, a, d, l, ex);
      if (n == 5) begin
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        lat_q.push_back(l);
        exp_q.push_back(ex);
        if (l > max_lat) begin
          max_lat = l;
        end
      end
    end
    $fclose(fd);
  endtask

  // Manager keeps a request up while the guard isolates the subordinate
  task automatic probe_isolation(input bit is_wr);
    if (is_wr) begin
      mgr_req.aw_addr  = 32'h00000f00;
      mgr_req.aw_valid = 1'b1;
      mgr_req.w_valid  = 1'b1;
      mgr_req.b_ready  = 1'b1;
    end else begin
      mgr_req.ar_addr  = 32'h00000f00;
      mgr_req.ar_valid = 1'b1;
      mgr_req.r_ready  = 1'b1;
    end
    for (int i = 0; i < PROBE_CYCLES; i++) begin
      @(negedge clk_i);
      assert (!sub_req.aw_valid && !sub_req.ar_valid)
        else report_mismatch("sub_req_o valid", 32'h0, {sub_req.aw_valid, sub_req.ar_valid});
      assert (!mgr_rsp.aw_ready && !mgr_rsp.ar_ready && !mgr_rsp.b_valid && !mgr_rsp.r_valid)
        else report_failure("manager request answered while isolated");
      next_cycle();
    end
    mgr_req = '0;
  endtask

  task automatic mgr_access(input bit is_wr, input logic [31:0] addr, input logic [31:0] data,
                            input int lat, input string ex);
    int cyc;
    bit accepted;
    bit responded;
    bit seen_irq;
    guard_bus_pkg::resp_e resp;
    logic [31:0] rdata;
    sub_latency = lat[15:0];
    if (is_wr) begin
      mgr_req.aw_addr  = addr;
      mgr_req.aw_valid = 1'b1;
      mgr_req.w_data   = data;
      mgr_req.w_strb   = 4'hf;
      mgr_req.w_valid  = 1'b1;
      mgr_req.b_ready  = 1'b1;
    end else begin
      mgr_req.ar_addr  = addr;
      mgr_req.ar_valid = 1'b1;
      mgr_req.r_ready  = 1'b1;
    end
    cyc = 0;
    accepted = 1'b0;
    while (!accepted && cyc < lat + 50) begin
      @(negedge clk_i);
      accepted = is_wr ? mgr_rsp.aw_ready : mgr_rsp.ar_ready;
      // Payload reaches the subordinate unchanged
      if (accepted && is_wr) begin
        assert (sub_req.aw_addr == addr)
          else report_mismatch("sub_req_o.aw_addr", addr, sub_req.aw_addr);
        assert (sub_req.w_data == data)
          else report_mismatch("sub_req_o.w_data", data, sub_req.w_data);
        assert (sub_req.w_strb == 4'hf)
          else report_mismatch("sub_req_o.w_strb", 32'hf, sub_req.w_strb);
      end else if (accepted) begin
        assert (sub_req.ar_addr == addr)
          else report_mismatch("sub_req_o.ar_addr", addr, sub_req.ar_addr);
      end
      next_cycle();
      cyc++;
    end
    mgr_req.aw_valid = 1'b0;
    mgr_req.w_valid  = 1'b0;
    mgr_req.ar_valid = 1'b0;
    responded = 1'b0;
    seen_irq  = 1'b0;
    while (accepted && !responded && !seen_irq && cyc < lat + 50) begin
      @(negedge clk_i);
      if (is_wr && mgr_rsp.b_valid) begin
        responded = 1'b1;
        resp      = mgr_rsp.b_resp;
      end else if (!is_wr && mgr_rsp.r_valid) begin
        responded = 1'b1;
        resp      = mgr_rsp.r_resp;
        rdata     = mgr_rsp.r_data;
      end else if (irq_o) begin
        seen_irq = 1'b1;
      end
      next_cycle();
      cyc++;
    end
    mgr_req.b_ready = 1'b0;
    mgr_req.r_ready = 1'b0;
    assert (accepted) else report_failure($sformatf("request to %h never accepted", addr));
    if (ex == "TO") begin
      assert (seen_irq) else report_failure($sformatf("no timeout flagged for %h", addr));
      if (seen_irq) begin
        assert (rst_req_o) else report_mismatch("rst_req_o", 32'h1, rst_req_o);
        probe_isolation(is_wr);
      end
    end else begin
      assert (responded) else report_failure($sformatf("no response for %h", addr));
      if (responded) begin
        assert (resp == guard_bus_pkg::OKAY) else report_mismatch("resp", 32'h0, resp);
        if (!is_wr) begin
          assert (rdata == (addr ^ 32'h5a5a0000))
            else report_mismatch("r_data", addr ^ 32'h5a5a0000, rdata);
        end
      end
      assert (!irq_o) else report_mismatch("irq_o", 32'h0, irq_o);
    end
  endtask

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    int cyc;
    bit done;
    cfg_req.aw_addr  = addr;
    cfg_req.aw_valid = 1'b1;
    cfg_req.w_data   = data;
    cfg_req.w_strb   = 4'hf;
    cfg_req.w_valid  = 1'b1;
    cfg_req.b_ready  = 1'b1;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < CFG_WAIT) begin
      @(negedge clk_i);
      done = cfg_rsp.aw_ready;
      next_cycle();
      cyc++;
    end
    cfg_req.aw_valid = 1'b0;
    cfg_req.w_valid  = 1'b0;
    assert (done) else report_failure("configuration write never accepted");
    done = 1'b0;
    while (!done && cyc < CFG_WAIT) begin
      @(negedge clk_i);
      done = cfg_rsp.b_valid;
      if (done) begin
        assert (cfg_rsp.b_resp == guard_bus_pkg::OKAY)
          else report_mismatch("cfg b_resp", 32'h0, cfg_rsp.b_resp);
      end
      next_cycle();
      cyc++;
    end
    cfg_req.b_ready = 1'b0;
    assert (done) else report_failure("configuration write got no response");
    // Clear pulse and monitor return to idle settle here
    repeat (3) next_cycle();
  endtask

  task automatic cfg_read(input logic [31:0] addr, input string ex);
    int cyc;
    bit done;
    logic [31:0] exp_val;
    cfg_req.ar_addr  = addr;
    cfg_req.ar_valid = 1'b1;
    cfg_req.r_ready  = 1'b1;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < CFG_WAIT) begin
      @(negedge clk_i);
      done = cfg_rsp.ar_ready;
      next_cycle();
      cyc++;
    end
    cfg_req.ar_valid = 1'b0;
    assert (done) else report_failure("configuration read never accepted");
    done = 1'b0;
    while (!done && cyc < CFG_WAIT) begin
      @(negedge clk_i);
      done = cfg_rsp.r_valid;
      if (done && ex == "SE") begin
        assert (cfg_rsp.r_resp == guard_bus_pkg::SLVERR)
          else report_mismatch("cfg r_resp", 32'h2, cfg_rsp.r_resp);
      end else if (done) begin
        void'($sscanf(ex, "%h", exp_val));
        assert (cfg_rsp.r_resp == guard_bus_pkg::OKAY)
          else report_mismatch("cfg r_resp", 32'h0, cfg_rsp.r_resp);
        assert (cfg_rsp.r_data == exp_val)
          else report_mismatch("cfg r_data", exp_val, cfg_rsp.r_data);
      end
      next_cycle();
      cyc++;
    end
    cfg_req.r_ready = 1'b0;
    assert (done) else report_failure("configuration read got no response");
  endtask

  // Watchdog sized from the number of operations and the longest latency
  initial begin
    wait (stim_loaded);
    #(op_q.size() * (max_lat + 50) * CLK_PERIOD);
    $display("ERROR: watchdog expired before the test sequence ended");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    errors      = 0;
    max_lat     = 0;
    stim_loaded = 1'b0;
    rst_n_i     = 1'b0;
    guard_ena_i = 1'b0;
    sub_latency = 16'd1;
    mgr_req     = '0;
    cfg_req     = '0;
    load_stimulus();
    stim_loaded = 1'b1;
    assert (op_q.size() > 0) else report_failure("stimulus file holds no operations");
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    next_cycle();
    foreach (op_q[i]) begin
      case (op_q[i])
        "MW": mgr_access(1'b1, addr_q[i], data_q[i], lat_q[i], exp_q[i]);
        "MR": mgr_access(1'b0, addr_q[i], data_q[i], lat_q[i], exp_q[i]);
        "CW": cfg_write(addr_q[i], data_q[i]);
        "CR": cfg_read(addr_q[i], exp_q[i]);
        "EN": begin
          guard_ena_i = data_q[i][0];
          next_cycle();
        end
        default: report_failure($sformatf("unknown operation %s", op_q[i]));
      endcase
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: sim/guard_stimulus.txt
# op addr data latency expect  (op: MW MR CW CR EN, hex addr and data, latency in cycles)
# expect: OK, TO (timeout), SE (SLVERR) or the hex value of a configuration read
EN 00000000 00000001 0 OK
MW 00001000 12345678 20 OK
MR 00002000 00000000 20 OK
CR 00000000 00000000 0 00000040
MW 00003004 cafe0001 300 TO
CR 0000000c 00000000 0 00003004
CR 00000008 00000000 0 00000001
CR 00000010 00000000 0 00000000
CW 00000008 00000001 0 OK
MW 00001010 00000011 20 OK
MR 00002020 00000000 300 TO
CR 0000000c 00000000 0 00002020
CR 00000008 00000000 0 00000002
CW 00000008 00000002 0 OK
MR 00002030 00000000 20 OK
MW 00001040 00000001 100 OK
CW 00000000 00000008 0 OK
CR 00000000 00000000 0 00000008
MW 00001050 00000002 100 TO
CW 00000008 00000001 0 OK
EN 00000000 00000000 0 OK
MW 00001060 00000003 300 OK
MR 00002060 00000000 300 OK
CR 00000008 00000000 0 00000000
CR 00000020 00000000 0 SE

// File: src.f
logic/guard_bus_pkg.sv
logic/guard_reg_pkg.sv
logic/guard_cfg_regs.sv
logic/write_guard.sv
logic/read_guard.sv
logic/slv_guard_top.sv
sim/axil_sub_model.sv
sim/tb_slv_guard.sv

// File: Bender.yml
package:
  name: slv_guard

sources:
  - logic/guard_bus_pkg.sv
  - logic/guard_reg_pkg.sv
  - logic/guard_cfg_regs.sv
  - logic/write_guard.sv
  - logic/read_guard.sv
  - logic/slv_guard_top.sv
  - target: simulation
    files:
      - sim/axil_sub_model.sv
      - sim/tb_slv_guard.sv
